//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/inst_fetch.sv
      - src/inst_decode.sv
      - src/reg_file.sv
      - src/alu_branch.sv
      - src/data_mem.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rv_core_properties.sv
      - tests/rv_core_tb.sv

//--- flist.f
+incdir+src
src/rv_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/alu_branch.sv
src/data_mem.sv
src/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

//--- src/alu_branch.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module alu_branch import rv_pkg::*; (
  input  id_ex_t              ex,
  output logic [`RV_XLEN-1:0] result,
  output logic                taken,
  output logic [`RV_XLEN-1:0] target
);

  logic [`RV_XLEN-1:0] op_a, op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic                eq;

  assign op_a = ex.rs1_val;
  assign op_b = (ex.ctrl.op == OP_ALU) ? ex.rs2_val : ex.ctrl.imm;
  assign eq   = (ex.rs1_val == ex.rs2_val);

  always_comb begin
    case (ex.ctrl.alu)
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_XOR: alu_out = op_a ^ op_b;
      ALU_SLT: alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_out = op_a + op_b;   // ADD, also load and store address
    endcase
  end

  always_comb begin
    case (ex.ctrl.op)
      OP_LUI:  result = ex.ctrl.imm;
      OP_JAL:  result = ex.pc + `RV_XLEN'd4;   // Link value
      default: result = alu_out;
    endcase
  end

  assign taken  = (ex.ctrl.op == OP_JAL) ||
                  (ex.ctrl.op == OP_BRANCH && (eq ^ ex.ctrl.bne));
  assign target = ex.pc + ex.ctrl.imm;

endmodule

//--- src/data_mem.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module data_mem import rv_pkg::*; (
  input  logic                clk_100mhz,
  input  ex_mem_t             mem,
  output logic [`RV_XLEN-1:0] rdata
);

  logic [`RV_XLEN-1:0]    ram [0:(1 << `RV_DMEM_AW)-1];
  logic [`RV_DMEM_AW-1:0] addr;

  assign addr = mem.result[`RV_DMEM_AW+1:2];   // Word index, low bits ignored

  always_ff @(posedge clk_100mhz) begin
    if (mem.op == OP_STORE) begin
      ram[addr] <= mem.store_data;
    end
    rdata <= ram[addr];   // Read-first
  end

endmodule

//--- src/inst_decode.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module inst_decode import rv_pkg::*; (
  input  inst_u inst,
  output ctrl_t ctrl,
  output logic  halt_word
);

  logic [2:0]          funct3;
  logic                sub_bit;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

  assign funct3  = inst.r_fmt.funct3;
  assign sub_bit = inst.r_fmt.funct7[5];

  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                  inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
  assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                  inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
  // U immediate is simply bits 31:12 of the word in their raw order
  assign imm_u = {inst.j_fmt.imm20, inst.j_fmt.imm10_1, inst.j_fmt.imm11,
                  inst.j_fmt.imm19_12, 12'b0};

  assign halt_word = (inst == '0);

  always_comb begin
    ctrl     = '0;   // NOP unless recognised
    ctrl.rs1 = inst.r_fmt.rs1;
    ctrl.rs2 = inst.r_fmt.rs2;
    ctrl.rd  = inst.r_fmt.rd;
    case (inst.r_fmt.opcode)
      `RV_OP_OP:     ctrl.op = OP_ALU;
      `RV_OP_OP_IMM: begin
        ctrl.op  = OP_ALUI;
        ctrl.imm = imm_i;
      end
      `RV_OP_LUI: begin
        ctrl.op  = OP_LUI;
        ctrl.imm = imm_u;
      end
      `RV_OP_LOAD: begin
        ctrl.op  = (funct3 == 3'b010) ? OP_LOAD : OP_NOP;   // LW only
        ctrl.imm = imm_i;
      end
      `RV_OP_STORE: begin
        ctrl.op  = (funct3 == 3'b010) ? OP_STORE : OP_NOP;  // SW only
        ctrl.imm = imm_s;
      end
      `RV_OP_BRANCH: begin
        ctrl.op  = (funct3[2:1] == 2'b00) ? OP_BRANCH : OP_NOP;   // BEQ, BNE
        ctrl.bne = funct3[0];
        ctrl.imm = imm_b;
      end
      `RV_OP_JAL: begin
        ctrl.op  = OP_JAL;
        ctrl.imm = imm_j;
      end
      default: ctrl.op = OP_NOP;
    endcase

    if (ctrl.op inside {OP_ALU, OP_ALUI}) begin
      case (funct3)
        3'b000:  ctrl.alu = (ctrl.op == OP_ALU && sub_bit) ? ALU_SUB : ALU_ADD;
        3'b010:  ctrl.alu = ALU_SLT;
        3'b100:  ctrl.alu = ALU_XOR;
        3'b110:  ctrl.alu = ALU_OR;
        3'b111:  ctrl.alu = ALU_AND;
        default: ctrl.op  = OP_NOP;   // Shifts and SLTU
      endcase
    end

    // Register fields the format does not carry read as x0
    if (!(ctrl.op inside {OP_ALU, OP_STORE, OP_BRANCH})) ctrl.rs2 = '0;
    if (ctrl.op inside {OP_NOP, OP_LUI, OP_JAL}) ctrl.rs1 = '0;
    if (ctrl.op inside {OP_NOP, OP_STORE, OP_BRANCH}) ctrl.rd = '0;
  end

endmodule

//--- src/inst_fetch.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module inst_fetch import rv_pkg::*; (
  input  logic                clk_100mhz,
  input  logic                sys_rst,
  input  logic                prog_we,
  input  prog_t               prog,
  input  logic                stall,
  input  logic                flush,
  input  logic [`RV_XLEN-1:0] target,
  input  logic                halt,
  output inst_u               inst,
  output logic [`RV_XLEN-1:0] pc_out
);

  logic [`RV_XLEN-1:0]    pc;
  logic [`RV_XLEN-1:0]    imem [0:(1 << `RV_IMEM_AW)-1];
  logic [`RV_IMEM_AW-1:0] rd_addr;

  assign rd_addr = pc[`RV_IMEM_AW+1:2];   // Word index

  // Program load port, used while the core sits in reset
  always_ff @(posedge clk_100mhz) begin
    if (prog_we) begin
      imem[prog.addr] <= prog.word;
    end
  end

  // inst and pc_out together form the word seen by decode
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      pc     <= '0;
      inst   <= `RV_NOP_WORD;
      pc_out <= '0;
    end else if (flush) begin
      pc   <= target;
      inst <= `RV_NOP_WORD;   // Kill the word already read
    end else if (!stall && !halt) begin
      inst   <= imem[rd_addr];
      pc_out <= pc;
      pc     <= pc + `RV_XLEN'd4;
    end
  end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file (
  input  logic                clk_100mhz,
  input  logic                sys_rst,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic                we,
  input  logic [4:0]          wa,
  input  logic [`RV_XLEN-1:0] wd,
  output logic [`RV_XLEN-1:0] rd1,
  output logic [`RV_XLEN-1:0] rd2
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NREG-1];   // x0 has no storage

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 1; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // Same-cycle write shows through on the read ports
  assign rd1 = (rs1 == '0) ? '0 : (we && wa == rs1) ? wd : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : (we && wa == rs2) ? wd : regs[rs2];

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
  input  logic  clk_100mhz,
  input  logic  sys_rst,
  input  logic  prog_we,
  input  prog_t prog,
  output logic  wb_valid,
  output wb_t   wb,
  output logic  halted
);

  inst_u               if_inst;
  logic [`RV_XLEN-1:0] if_pc;
  ctrl_t               dec_ctrl;
  logic                halt_word;
  logic [`RV_XLEN-1:0] rf_rd1, rf_rd2;
  logic [`RV_XLEN-1:0] fwd1, fwd2;
  logic                stall, flush;
  id_ex_t              id_ex_d, id_ex;
  ex_mem_t             ex_mem_d, ex_mem;
  mem_wb_t             mem_wb;
  logic [`RV_XLEN-1:0] ex_result, br_target;
  logic                br_taken;
  logic [`RV_XLEN-1:0] dmem_rdata, mem_val;
  logic                wb_we;
  logic                halt_issued;
  logic [2:0]          halt_pipe;   // Halt marker in memory, writeback, gone

  function automatic logic writes_rd(input op_e op);
    return op inside {OP_ALU, OP_ALUI, OP_LUI, OP_LOAD, OP_JAL};
  endfunction

  // Youngest producer wins
  function automatic logic [`RV_XLEN-1:0] fwd_val(input logic [4:0] rs,
                                                  input logic [`RV_XLEN-1:0] rf_val);
    if (rs == '0) return '0;
    if (writes_rd(id_ex.ctrl.op) && id_ex.ctrl.rd == rs) return ex_result;
    if (writes_rd(ex_mem.op) && ex_mem.rd == rs) return mem_val;
    if (writes_rd(mem_wb.op) && mem_wb.rd == rs) return mem_wb.value;
    return rf_val;
  endfunction

  inst_fetch u_inst_fetch (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .prog_we    (prog_we),
    .prog       (prog),
    .stall      (stall),
    .flush      (flush),
    .target     (br_target),
    .halt       (halt_word),
    .inst       (if_inst),
    .pc_out     (if_pc)
  );

  inst_decode u_inst_decode (
    .inst      (if_inst),
    .ctrl      (dec_ctrl),
    .halt_word (halt_word)
  );

  reg_file u_reg_file (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .rs1        (dec_ctrl.rs1),
    .rs2        (dec_ctrl.rs2),
    .we         (wb_we),
    .wa         (mem_wb.rd),
    .wd         (mem_wb.value),
    .rd1        (rf_rd1),
    .rd2        (rf_rd2)
  );

  alu_branch u_alu_branch (
    .ex     (id_ex),
    .result (ex_result),
    .taken  (br_taken),
    .target (br_target)
  );

  // Memory access launches as the instruction leaves execute,
  // so load data is ready while it sits in the memory stage
  data_mem u_data_mem (
    .clk_100mhz (clk_100mhz),
    .mem        (ex_mem_d),
    .rdata      (dmem_rdata)
  );

  assign flush = br_taken;
  // Load in execute feeding decode, hold one cycle
  assign stall = (id_ex.ctrl.op == OP_LOAD) && (id_ex.ctrl.rd != '0) &&
                 (id_ex.ctrl.rd == dec_ctrl.rs1 || id_ex.ctrl.rd == dec_ctrl.rs2);

  always_comb begin
    fwd1 = fwd_val(dec_ctrl.rs1, rf_rd1);
    fwd2 = fwd_val(dec_ctrl.rs2, rf_rd2);
  end

  always_comb begin
    id_ex_d = '{ctrl: dec_ctrl, pc: if_pc, rs1_val: fwd1, rs2_val: fwd2};
    if (stall || flush) begin
      id_ex_d.ctrl.op = OP_NOP;   // Bubble or squashed younger instruction
    end
  end

  assign ex_mem_d = '{op: id_ex.ctrl.op, rd: id_ex.ctrl.rd,
                      result: ex_result, store_data: id_ex.rs2_val};
  assign mem_val  = (ex_mem.op == OP_LOAD) ? dmem_rdata : ex_mem.result;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      id_ex.ctrl.op <= OP_NOP;
      ex_mem.op     <= OP_NOP;
      mem_wb.op     <= OP_NOP;
    end else begin
      id_ex  <= id_ex_d;
      ex_mem <= ex_mem_d;
      mem_wb <= '{op: ex_mem.op, rd: ex_mem.rd, value: mem_val};
    end
  end

  assign wb_we = writes_rd(mem_wb.op) && (mem_wb.rd != '0);

  // Retire port trails the register file write by one cycle
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= wb_we;
    end
    wb <= '{rd: mem_wb.rd, data: mem_wb.value};
  end

  // Halt word enters execute once unless an older redirect kills it
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      halt_issued <= 1'b0;
      halt_pipe   <= '0;
    end else begin
      halt_issued <= halt_issued | (halt_word & ~flush);
      halt_pipe   <= {halt_pipe[1:0], halt_issued};
    end
  end

  assign halted = halt_pipe[2];

endmodule

//--- src/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN     32
`define RV_NREG     32
`define RV_IMEM_AW  8   // Instruction memory depth, log2 of words
`define RV_DMEM_AW  8   // Data memory depth, log2 of words

// addi x0, x0, 0
`define RV_NOP_WORD 32'h0000_0013

// Major opcodes
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

`endif

//--- src/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

  // Instruction word views
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    OP_NOP, OP_ALU, OP_ALUI, OP_LUI, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL
  } op_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } alu_e;

  typedef struct packed {
    op_e                 op;
    alu_e                alu;
    logic                bne;      // Branch when operands differ
    logic [4:0]          rs1, rs2, rd;
    logic [`RV_XLEN-1:0] imm;
  } ctrl_t;

  typedef struct packed {
    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_val, rs2_val;   // Already forwarded
  } id_ex_t;

  // result is the byte address for LOAD and STORE
  typedef struct packed {
    op_e                 op;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] store_data;
  } ex_mem_t;

  typedef struct packed {
    op_e                 op;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] value;
  } mem_wb_t;

  typedef struct packed {
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic [`RV_IMEM_AW-1:0] addr;   // Word address
    logic [`RV_XLEN-1:0]    word;
  } prog_t;

endpackage

//--- tests/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties import rv_pkg::*; (
  input logic clk_100mhz,
  input logic sys_rst,
  input logic stall,
  input logic flush,
  input logic wb_valid,
  input wb_t  wb,
  input logic halted
);

  // Load-use bubble and redirect come from different execute ops
  a_stall_flush: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !(stall && flush))
    else $error("stall and flush high in the same cycle");

  a_no_x0_retire: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    wb_valid |-> (wb.rd != 5'd0))
    else $error("retire port strobed a write to x0");

  // Halted is sticky until reset
  a_halt_sticky: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    halted |=> halted)
    else $error("halted fell without reset");

endmodule

bind rv_core rv_core_properties u_rv_core_properties (.*);

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_tb import rv_pkg::*; ();

  logic  clk_100mhz;
  logic  sys_rst;
  logic  prog_we;
  prog_t prog;
  logic  wb_valid;
  wb_t   wb;
  logic  halted;

  logic [31:0] prog_words [$];   // Program table, word i at pc 4*i
  logic [4:0]  exp_rd [$];       // Expected writes in program order
  logic [31:0] exp_data [$];
  int          seen;
  logic        table_ready;
  int          seed_val;

  rv_core u_rv_core (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .prog_we    (prog_we),
    .prog       (prog),
    .wb_valid   (wb_valid),
    .wb         (wb),
    .halted     (halted)
  );

  initial clk_100mhz = 1'b0;
  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Instruction encoders by format
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  task automatic append_word(input logic [31:0] word);
    prog_words.push_back(word);
  endtask

  task automatic expect_write(input logic [4:0] rd, input logic [31:0] data);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stop_with_failure($sformatf("ERR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic build_program();
    logic [11:0] i1, i2, i3;
    logic [31:0] s1, s2, s3, v3, v5, v8, v9, v10, v12, link;
    i1  = 12'($urandom);
    i2  = 12'($urandom);
    i3  = 12'($urandom);
    s1  = sext12(i1);
    s2  = sext12(i2);
    s3  = sext12(i3);
    v3  = s1 + s2;
    v5  = 32'hffff_fffb;
    v8  = v3 ^ s1;
    v9  = v8 & s2;
    v10 = v9 | s3;
    v12 = (v10 & v8) | v9;
    append_word(i_type(i1, 5'd0, 3'b000, 5'd1, `RV_OP_OP_IMM));   // addi x1, x0, i1
    expect_write(5'd1, s1);
    append_word(i_type(i2, 5'd0, 3'b000, 5'd2, `RV_OP_OP_IMM));
    expect_write(5'd2, s2);
    append_word(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));   // add x3, x1, x2
    expect_write(5'd3, v3);
    append_word(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));   // sub, x1 three back
    expect_write(5'd4, v3 - s1);
    append_word(i_type(12'hffb, 5'd0, 3'b000, 5'd5, `RV_OP_OP_IMM));
    expect_write(5'd5, v5);
    append_word(r_type(7'h00, 5'd1, 5'd5, 3'b010, 5'd6));   // slt x6, x5, x1
    expect_write(5'd6, {31'b0, $signed(v5) < $signed(s1)});
    append_word(i_type(i3, 5'd5, 3'b010, 5'd7, `RV_OP_OP_IMM));   // slti
    expect_write(5'd7, {31'b0, $signed(v5) < $signed(s3)});
    append_word(i_type(i1, 5'd3, 3'b100, 5'd8, `RV_OP_OP_IMM));   // xori
    expect_write(5'd8, v8);
    append_word(i_type(i2, 5'd8, 3'b111, 5'd9, `RV_OP_OP_IMM));   // andi
    expect_write(5'd9, v9);
    append_word(i_type(i3, 5'd9, 3'b110, 5'd10, `RV_OP_OP_IMM));  // ori
    expect_write(5'd10, v10);
    append_word(r_type(7'h00, 5'd8, 5'd10, 3'b111, 5'd11));   // and x11, x10, x8
    expect_write(5'd11, v10 & v8);
    append_word(r_type(7'h00, 5'd9, 5'd11, 3'b110, 5'd12));   // or x12, x11, x9
    expect_write(5'd12, v12);
    append_word(r_type(7'h00, 5'd5, 5'd12, 3'b100, 5'd13));   // xor x13, x12, x5
    expect_write(5'd13, v12 ^ v5);
    append_word(u_type(20'h12345, 5'd14));
    expect_write(5'd14, 32'h1234_5000);
    append_word(s_type(12'd16, 5'd14, 5'd0));   // sw x14, 16(x0)
    append_word(i_type(12'd16, 5'd0, 3'b010, 5'd15, `RV_OP_LOAD));
    expect_write(5'd15, 32'h1234_5000);
    append_word(r_type(7'h00, 5'd3, 5'd15, 3'b000, 5'd16));   // Load-use stall
    expect_write(5'd16, 32'h1234_5000 + v3);
    append_word(i_type(12'd7, 5'd1, 3'b000, 5'd0, `RV_OP_OP_IMM));   // addi x0, never retires
    append_word(r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd17));   // add x17, x0, x2
    expect_write(5'd17, s2);
    append_word(b_type(13'd12, 5'd1, 5'd1, 3'b000));   // beq taken, skips two
    append_word(i_type(12'd1, 5'd0, 3'b000, 5'd18, `RV_OP_OP_IMM));
    append_word(i_type(12'd2, 5'd0, 3'b000, 5'd19, `RV_OP_OP_IMM));
    append_word(b_type(13'd8, 5'd2, 5'd2, 3'b001));   // bne not taken
    append_word(i_type(12'd3, 5'd0, 3'b000, 5'd20, `RV_OP_OP_IMM));
    expect_write(5'd20, 32'd3);
    link = prog_words.size() * 4 + 4;
    append_word(j_type(21'd12, 5'd21));   // jal x21, skips two
    expect_write(5'd21, link);
    append_word(i_type(12'd4, 5'd0, 3'b000, 5'd22, `RV_OP_OP_IMM));
    append_word(i_type(12'd5, 5'd0, 3'b000, 5'd23, `RV_OP_OP_IMM));
    append_word(i_type(12'd1, 5'd21, 3'b000, 5'd24, `RV_OP_OP_IMM));
    expect_write(5'd24, link + 1);
    append_word(32'h0000_0000);   // Halt
  endtask

  initial begin
    seed_val    = $urandom(23841);
    sys_rst     = 1'b1;
    prog_we     = 1'b0;
    prog        = '0;
    seen        = 0;
    table_ready = 1'b0;
    build_program();
    table_ready = 1'b1;
    repeat (2) @(negedge clk_100mhz);
    for (int i = 0; i < prog_words.size(); i++) begin
      @(negedge clk_100mhz);
      prog_we   = 1'b1;
      prog.addr = i[`RV_IMEM_AW-1:0];
      prog.word = prog_words[i];
    end
    @(negedge clk_100mhz);
    prog_we = 1'b0;
    sys_rst = 1'b0;
    wait (halted === 1'b1);
    repeat (10) @(negedge clk_100mhz);   // Quiet period after halt
    if (seen != exp_rd.size()) begin
      check_value("retire count", exp_rd.size(), seen);
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // Retire monitor, sampled away from the active edge
  always @(negedge clk_100mhz) begin
    if (!sys_rst && wb_valid === 1'b1) begin
      if (halted === 1'b1) begin
        stop_with_failure("A register write retired after the core halted");
      end else if (seen >= exp_rd.size()) begin
        stop_with_failure("More register writes retired than the program makes");
      end else begin
        check_value($sformatf("retire %0d rd", seen), exp_rd[seen], wb.rd);
        check_value($sformatf("retire %0d data", seen), exp_data[seen], wb.data);
        seen++;
      end
    end
  end

  // Watchdog, 20 cycles per program word
  initial begin
    wait (table_ready === 1'b1);
    repeat (prog_words.size() * 20) @(posedge clk_100mhz);
    stop_with_failure($sformatf("Timeout: the core never halted within %0d cycles",
                                prog_words.size() * 20));
  end

endmodule
